/* hdl/cw_reg_pkg.sv */
////////////////////
// register map of the host side, one byte per access
// multi-byte registers are indexed by the byte count, little-endian
////////////////////
`default_nettype none

package cw_reg_pkg;

   typedef logic [7:0] reg_addr_t;     // register address
   typedef logic [7:0] reg_byte_t;     // one data byte
   typedef logic [6:0] reg_bytecnt_t;  // byte index in a wide register
   typedef logic [2:0] clksettings_t;  // clock select field

   ////////////////////
   // register addresses
   ////////////////////
   localparam reg_addr_t reg_clksettings_addr     = 8'h00;
   localparam reg_addr_t reg_user_led_addr        = 8'h01;
   localparam reg_addr_t reg_crypt_type_addr      = 8'h02;
   localparam reg_addr_t reg_crypt_rev_addr       = 8'h03;
   localparam reg_addr_t reg_identify_addr        = 8'h04;
   localparam reg_addr_t reg_crypt_go_addr        = 8'h05;  // write: go, read: busy
   localparam reg_addr_t reg_crypt_key_addr       = 8'h06;
   localparam reg_addr_t reg_crypt_textin_addr    = 8'h07;
   localparam reg_addr_t reg_crypt_cipherin_addr  = 8'h08;
   localparam reg_addr_t reg_crypt_textout_addr   = 8'h09;
   localparam reg_addr_t reg_crypt_cipherout_addr = 8'h0A;

   ////////////////////
   // identification
   ////////////////////
   localparam reg_byte_t crypt_type_value = 8'd2;
   localparam reg_byte_t crypt_rev_value  = 8'd4;
   localparam reg_byte_t identify_value   = 8'h2E;  // fixed target id

endpackage

`default_nettype wire

/* hdl/crypt_pkg.sv */
////////////////////
// crypto data widths, all registers are 128 bits
////////////////////
`default_nettype none

package crypt_pkg;

   typedef logic [127:0] key_t;
   typedef logic [127:0] text_t;
   typedef logic [127:0] cipher_t;

   // bytes per crypto register, higher byte counts are ignored
   localparam int unsigned crypt_bytes = 16;

   typedef logic [3:0] crypt_byte_sel_t;  // byte within a crypto register

endpackage

`default_nettype wire

/* hdl/reg_bus_if.sv */
////////////////////
// host access fields, byte loads and the crypto register view
// all signals live in the usb_clk domain
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;
   import cw_reg_pkg::*;

   reg_addr_t    address;
   reg_bytecnt_t bytecnt;
   reg_byte_t    write_data;
   logic         write;      // qualified by addrvalid
   logic         read;
   logic         addrvalid;

   modport decoder (input address, bytecnt, write_data, write, addrvalid);
   modport reader  (input address, bytecnt, read, addrvalid);
endinterface

// one strobe at most per cycle, combinational from the host write
interface crypt_load_if;
   import cw_reg_pkg::*;
   import crypt_pkg::*;

   logic            load_key;
   logic            load_textin;
   logic            load_cipherin;
   crypt_byte_sel_t byte_sel;
   reg_byte_t       byte_data;

   modport src (output load_key, load_textin, load_cipherin, byte_sel, byte_data);
   modport dst (input load_key, load_textin, load_cipherin, byte_sel, byte_data);
endinterface

interface crypt_view_if;
   import crypt_pkg::*;

   key_t    key;
   text_t   textin;
   cipher_t cipherin;
   text_t   textout;    // captured on done
   cipher_t cipherout;
endinterface

`default_nettype wire

/* hdl/usb_reg_write.sv */
////////////////////
// host write decode, byte loads are combinational
// go pulse is registered, one cycle after the write
////////////////////
`timescale 1ns/1ps
`default_nettype none

module usb_reg_write (
   input  logic                     usb_clk,
   input  logic                     reset_i,
   reg_bus_if.decoder               bus_i,
   crypt_load_if.src                load_o,
   output cw_reg_pkg::clksettings_t clksettings_o,
   output logic                     user_led_o,
   output logic                     go_pulse_o
);
   import cw_reg_pkg::*;
   import crypt_pkg::*;

   logic wr_qual;
   logic byte_ok;

   assign wr_qual = bus_i.write & bus_i.addrvalid;
   assign byte_ok = (bus_i.bytecnt < reg_bytecnt_t'(crypt_bytes));

   ////////////////////
   // crypto byte loads
   ////////////////////
   always_comb begin
      load_o.load_key      = 1'b0;
      load_o.load_textin   = 1'b0;
      load_o.load_cipherin = 1'b0;
      if (wr_qual && byte_ok) begin   // out of range counts load nothing
         case (bus_i.address)
            reg_crypt_key_addr:      load_o.load_key      = 1'b1;
            reg_crypt_textin_addr:   load_o.load_textin   = 1'b1;
            reg_crypt_cipherin_addr: load_o.load_cipherin = 1'b1;
            default: ;
         endcase
      end
   end

   assign load_o.byte_sel  = bus_i.bytecnt[$bits(crypt_byte_sel_t)-1:0];
   assign load_o.byte_data = bus_i.write_data;

   ////////////////////
   // config registers and go
   ////////////////////
   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         clksettings_o <= '0;
         user_led_o    <= 1'b0;
         go_pulse_o    <= 1'b0;
      end else begin
         // single cycle, data byte is don't care
         go_pulse_o <= wr_qual && (bus_i.address == reg_crypt_go_addr);

         if (wr_qual) begin
            case (bus_i.address)
               reg_clksettings_addr:
                  clksettings_o <= bus_i.write_data[$bits(clksettings_t)-1:0];
               reg_user_led_addr:
                  user_led_o <= bus_i.write_data[0];   // bit 0 only
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/crypt_reg_bank.sv */
////////////////////
// key, text and cipher storage, not reset
// results are captured once per rising edge of done
////////////////////
`timescale 1ns/1ps
`default_nettype none

module crypt_reg_bank (
   input  logic               usb_clk,
   input  logic               done_i,
   input  crypt_pkg::text_t   textout_i,
   input  crypt_pkg::cipher_t cipherout_i,
   crypt_load_if.dst          load_i,
   crypt_view_if              view_o
);
   import crypt_pkg::*;

   key_t    key_r;
   text_t   textin_r;
   cipher_t cipherin_r;
   text_t   textout_r;
   cipher_t cipherout_r;

   logic    done_r;
   logic    done_rise;

   ////////////////////
   // host byte loads
   ////////////////////
   always_ff @(posedge usb_clk) begin
      if (load_i.load_key)
         key_r[{load_i.byte_sel, 3'b000} +: 8] <= load_i.byte_data;
      if (load_i.load_textin)
         textin_r[{load_i.byte_sel, 3'b000} +: 8] <= load_i.byte_data;
      if (load_i.load_cipherin)
         cipherin_r[{load_i.byte_sel, 3'b000} +: 8] <= load_i.byte_data;
   end

   ////////////////////
   // result capture
   ////////////////////
   assign done_rise = done_i & ~done_r;   // edge only, long done is fine

   always_ff @(posedge usb_clk) begin
      done_r <= done_i;
      if (done_rise) begin
         textout_r   <= textout_i;
         cipherout_r <= cipherout_i;
      end
   end

   assign view_o.key       = key_r;
   assign view_o.textin    = textin_r;
   assign view_o.cipherin  = cipherin_r;
   assign view_o.textout   = textout_r;
   assign view_o.cipherout = cipherout_r;

endmodule

`default_nettype wire

/* hdl/crypt_start_ctrl.sv */
////////////////////
// trigger to start is 2 cycles from the first sample
// busy status lags the core by 3 edges
////////////////////
`timescale 1ns/1ps
`default_nettype none

module crypt_start_ctrl (
   input  logic usb_clk,
   input  logic reset_i,
   input  logic exttrigger_i,
   input  logic go_pulse_i,
   input  logic busy_i,
   output logic start_o,
   output logic busy_sync_o
);

   logic       trig_meta;
   logic       trig_sync;
   logic       trig_prev;
   logic       trig_pulse;   // registered rising edge
   logic [2:0] busy_pipe;

   always_ff @(posedge usb_clk) begin
      if (reset_i) begin
         trig_meta  <= 1'b0;
         trig_sync  <= 1'b0;
         trig_prev  <= 1'b0;
         trig_pulse <= 1'b0;
         busy_pipe  <= '0;
      end else begin
         trig_meta  <= exttrigger_i;
         trig_sync  <= trig_meta;
         trig_prev  <= trig_sync;
         trig_pulse <= trig_sync & ~trig_prev;
         busy_pipe  <= {busy_pipe[1:0], busy_i};
      end
   end

   // either source, both are already one cycle wide
   assign start_o     = go_pulse_i | trig_pulse;
   assign busy_sync_o = busy_pipe[2];

endmodule

`default_nettype wire

/* hdl/usb_reg_read.sv */
////////////////////
// combinational read-back, zero unless a read is valid
////////////////////
`timescale 1ns/1ps
`default_nettype none

module usb_reg_read (
   reg_bus_if.reader                bus_i,
   crypt_view_if                    view_i,
   input  cw_reg_pkg::clksettings_t clksettings_i,
   input  logic                     user_led_i,
   input  logic                     busy_i,
   output cw_reg_pkg::reg_byte_t    read_data_o
);
   import cw_reg_pkg::*;
   import crypt_pkg::*;

   // one byte of a crypto register, zero past the last byte
   function automatic reg_byte_t pick_byte(input text_t value, input reg_bytecnt_t idx);
      crypt_byte_sel_t sel;
      sel = idx[$bits(crypt_byte_sel_t)-1:0];
      if (idx < reg_bytecnt_t'(crypt_bytes))
         return value[{sel, 3'b000} +: 8];
      return '0;
   endfunction

   always_comb begin
      read_data_o = '0;
      if (bus_i.read && bus_i.addrvalid) begin
         case (bus_i.address)
            reg_clksettings_addr:
               read_data_o = {{($bits(reg_byte_t) - $bits(clksettings_t)){1'b0}},
                              clksettings_i};
            reg_user_led_addr:        read_data_o = {7'b0, user_led_i};
            reg_crypt_type_addr:      read_data_o = crypt_type_value;
            reg_crypt_rev_addr:       read_data_o = crypt_rev_value;
            reg_identify_addr:        read_data_o = identify_value;
            reg_crypt_go_addr:        read_data_o = {7'b0, busy_i};  // synced busy
            reg_crypt_key_addr:       read_data_o = pick_byte(view_i.key, bus_i.bytecnt);
            reg_crypt_textin_addr:    read_data_o = pick_byte(view_i.textin, bus_i.bytecnt);
            reg_crypt_cipherin_addr:  read_data_o = pick_byte(view_i.cipherin, bus_i.bytecnt);
            reg_crypt_textout_addr:   read_data_o = pick_byte(view_i.textout, bus_i.bytecnt);
            reg_crypt_cipherout_addr: read_data_o = pick_byte(view_i.cipherout, bus_i.bytecnt);
            default:                  read_data_o = '0;  // unmapped
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/cw_reg_top.sv */
////////////////////
// single clock register file, everything on usb_clk
// crypto registers hold no reset value
////////////////////
`timescale 1ns/1ps
`default_nettype none

module cw_reg_top (
   input  logic                     usb_clk,
   input  logic                     reset_i,

   // host register bus
   input  cw_reg_pkg::reg_addr_t    reg_address_i,
   input  cw_reg_pkg::reg_bytecnt_t reg_bytecnt_i,
   input  cw_reg_pkg::reg_byte_t    write_data_i,
   input  logic                     reg_write_i,
   input  logic                     reg_read_i,
   input  logic                     reg_addrvalid_i,
   output cw_reg_pkg::reg_byte_t    read_data_o,

   input  logic                     exttrigger_i,

   // crypto core
   input  logic                     crypt_done_i,
   input  logic                     crypt_busy_i,
   input  crypt_pkg::text_t         crypt_textout_i,
   input  crypt_pkg::cipher_t       crypt_cipherout_i,
   output cw_reg_pkg::clksettings_t clksettings_o,
   output logic                     user_led_o,
   output crypt_pkg::key_t          crypt_key_o,
   output crypt_pkg::text_t         crypt_textin_o,
   output crypt_pkg::cipher_t       crypt_cipherin_o,
   output logic                     crypt_start_o
);

   logic go_pulse;
   logic busy_sync;

   reg_bus_if    reg_bus ();
   crypt_load_if crypt_load ();
   crypt_view_if crypt_view ();

   ////////////////////
   // host bus into the interface
   ////////////////////
   assign reg_bus.address    = reg_address_i;
   assign reg_bus.bytecnt    = reg_bytecnt_i;
   assign reg_bus.write_data = write_data_i;
   assign reg_bus.write      = reg_write_i;
   assign reg_bus.read       = reg_read_i;
   assign reg_bus.addrvalid  = reg_addrvalid_i;

   usb_reg_write u_usb_reg_write (
      .usb_clk       (usb_clk),
      .reset_i       (reset_i),
      .bus_i         (reg_bus),
      .load_o        (crypt_load),
      .clksettings_o (clksettings_o),
      .user_led_o    (user_led_o),
      .go_pulse_o    (go_pulse)
   );

   crypt_reg_bank u_crypt_reg_bank (
      .usb_clk     (usb_clk),
      .done_i      (crypt_done_i),
      .textout_i   (crypt_textout_i),
      .cipherout_i (crypt_cipherout_i),
      .load_i      (crypt_load),
      .view_o      (crypt_view)
   );

   crypt_start_ctrl u_crypt_start_ctrl (
      .usb_clk      (usb_clk),
      .reset_i      (reset_i),
      .exttrigger_i (exttrigger_i),
      .go_pulse_i   (go_pulse),
      .busy_i       (crypt_busy_i),
      .start_o      (crypt_start_o),
      .busy_sync_o  (busy_sync)
   );

   usb_reg_read u_usb_reg_read (
      .bus_i         (reg_bus),
      .view_i        (crypt_view),
      .clksettings_i (clksettings_o),
      .user_led_i    (user_led_o),
      .busy_i        (busy_sync),
      .read_data_o   (read_data_o)
   );

   // stored inputs straight to the core
   assign crypt_key_o      = crypt_view.key;
   assign crypt_textin_o   = crypt_view.textin;
   assign crypt_cipherin_o = crypt_view.cipherin;

endmodule

`default_nettype wire

/* verification/cw_reg_props.sv */
////////////////////
// pin level checks, bound into cw_reg_top
////////////////////
`timescale 1ns/1ps
`default_nettype none

module cw_reg_props (
   input logic                     usb_clk,
   input logic                     reset_i,
   input cw_reg_pkg::reg_addr_t    reg_address_i,
   input logic                     reg_write_i,
   input logic                     reg_read_i,
   input logic                     reg_addrvalid_i,
   input cw_reg_pkg::reg_byte_t    read_data_o,
   input logic                     exttrigger_i,
   input logic                     crypt_busy_i,
   input cw_reg_pkg::clksettings_t clksettings_o,
   input logic                     user_led_o,
   input logic                     crypt_start_o
);
   import cw_reg_pkg::*;

   int unsigned fail_count = 0;   // polled by the testbench
   logic        go_write;
   logic        go_read;

   assign go_write = reg_write_i && reg_addrvalid_i && (reg_address_i == reg_crypt_go_addr);
   assign go_read  = reg_read_i && reg_addrvalid_i && (reg_address_i == reg_crypt_go_addr);

   reset_clears: assert property (@(posedge usb_clk)
      reset_i |=> (!crypt_start_o && !user_led_o && clksettings_o == '0))
   else begin
      $error("outputs not cleared by reset");
      fail_count++;
   end

   idle_read_zero: assert property (@(posedge usb_clk)
      !(reg_read_i && reg_addrvalid_i) |-> read_data_o == '0)
   else begin
      $error("read data not zero without a valid read");
      fail_count++;
   end

   go_starts: assert property (@(posedge usb_clk) disable iff (reset_i)
      go_write |=> crypt_start_o)
   else begin
      $error("go write gave no start pulse");
      fail_count++;
   end

   ////////////////////
   // a start needs a go write or a trigger edge 3 edges back
   ////////////////////
   start_source: assert property (@(posedge usb_clk) disable iff (reset_i)
      crypt_start_o |-> ($past(go_write) || ($past(exttrigger_i, 3) && !$past(exttrigger_i, 4))))
   else begin
      $error("start pulse without a go write or a trigger edge");
      fail_count++;
   end

   busy_status: assert property (@(posedge usb_clk) disable iff (reset_i)
      go_read |-> read_data_o == {7'b0, $past(crypt_busy_i, 3)})
   else begin
      $error("busy status does not follow the core after 3 edges");
      fail_count++;
   end

endmodule

bind cw_reg_top cw_reg_props u_props (
   .usb_clk         (usb_clk),
   .reset_i         (reset_i),
   .reg_address_i   (reg_address_i),
   .reg_write_i     (reg_write_i),
   .reg_read_i      (reg_read_i),
   .reg_addrvalid_i (reg_addrvalid_i),
   .read_data_o     (read_data_o),
   .exttrigger_i    (exttrigger_i),
   .crypt_busy_i    (crypt_busy_i),
   .clksettings_o   (clksettings_o),
   .user_led_o      (user_led_o),
   .crypt_start_o   (crypt_start_o)
);

`default_nettype wire

/* verification/cw_reg_tb.sv */
////////////////////
// inputs change after the rising edge, outputs are checked at the falling edge
// crypto byte order is little-endian, byte count 0 is bits 7:0
////////////////////
`timescale 1ns/1ps
`default_nettype none

module cw_reg_tb;
   import cw_reg_pkg::*;
   import crypt_pkg::*;

   localparam int clk_period   = 40;
   localparam int reset_cycles = 4;
   localparam int num_accesses = 160;   // host reads and writes, 2 cycles each
   localparam int timeout_ns   = (reset_cycles + 4 * num_accesses) * clk_period;

   int           seed = 4;
   logic         usb_clk;
   logic         reset;
   reg_addr_t    reg_address;
   reg_bytecnt_t reg_bytecnt;
   reg_byte_t    write_data;
   logic         reg_write;
   logic         reg_read;
   logic         reg_addrvalid;
   reg_byte_t    read_data;
   logic         exttrigger;
   logic         crypt_done;
   logic         crypt_busy;
   text_t        crypt_textout;
   cipher_t      crypt_cipherout;
   clksettings_t clksettings;
   logic         user_led;
   key_t         crypt_key;
   text_t        crypt_textin;
   cipher_t      crypt_cipherin;
   logic         crypt_start;
   logic [127:0] key_exp;
   logic [127:0] textin_exp;
   logic [127:0] cipherin_exp;
   logic [127:0] textout_exp;
   logic [127:0] cipherout_exp;

   cw_reg_top u_cw_reg_top (
      .usb_clk           (usb_clk),
      .reset_i           (reset),
      .reg_address_i     (reg_address),
      .reg_bytecnt_i     (reg_bytecnt),
      .write_data_i      (write_data),
      .reg_write_i       (reg_write),
      .reg_read_i        (reg_read),
      .reg_addrvalid_i   (reg_addrvalid),
      .read_data_o       (read_data),
      .exttrigger_i      (exttrigger),
      .crypt_done_i      (crypt_done),
      .crypt_busy_i      (crypt_busy),
      .crypt_textout_i   (crypt_textout),
      .crypt_cipherout_i (crypt_cipherout),
      .clksettings_o     (clksettings),
      .user_led_o        (user_led),
      .crypt_key_o       (crypt_key),
      .crypt_textin_o    (crypt_textin),
      .crypt_cipherin_o  (crypt_cipherin),
      .crypt_start_o     (crypt_start)
   );

   initial begin
      usb_clk = 1'b0;
      forever #(clk_period / 2) usb_clk = ~usb_clk;
   end

   ////////////////////
   // checks and host accesses
   ////////////////////
   task automatic check_byte(input string name, input reg_byte_t exp, input reg_byte_t act);
      assert (act === exp) else begin
         $display("CHECK FAILED %s expected 0x%02h got 0x%02h", name, exp, act);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   task automatic check_word(input string name, input logic [127:0] exp, input logic [127:0] act);
      assert (act === exp) else begin
         $display("CHECK FAILED %s expected 0x%032h got 0x%032h", name, exp, act);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   task automatic bus_idle();
      reg_write     <= 1'b0;
      reg_read      <= 1'b0;
      reg_addrvalid <= 1'b0;
   endtask

   // sampled by the DUT at the second edge
   task automatic host_write(input reg_addr_t addr, input int cnt, input reg_byte_t data);
      @(posedge usb_clk);
      reg_address   <= addr;
      reg_bytecnt   <= reg_bytecnt_t'(cnt);
      write_data    <= data;
      reg_write     <= 1'b1;
      reg_addrvalid <= 1'b1;
      @(posedge usb_clk);
      bus_idle();
   endtask

   task automatic host_read(input reg_addr_t addr, input int cnt, input reg_byte_t exp);
      @(posedge usb_clk);
      reg_address   <= addr;
      reg_bytecnt   <= reg_bytecnt_t'(cnt);
      reg_read      <= 1'b1;
      reg_addrvalid <= 1'b1;
      @(negedge usb_clk);
      check_byte("read_data_o", exp, read_data);
      @(posedge usb_clk);
      bus_idle();
   endtask

   task automatic write_word(input reg_addr_t addr, input logic [127:0] value);
      for (int b = 0; b < crypt_bytes; b++)
         host_write(addr, b, value[8*b +: 8]);
   endtask

   task automatic read_word(input reg_addr_t addr, input logic [127:0] exp);
      for (int b = 0; b < crypt_bytes; b++)
         host_read(addr, b, exp[8*b +: 8]);
   endtask

   function automatic logic [127:0] random_word();
      logic [127:0] w;
      for (int b = 0; b < crypt_bytes; b++)
         w[8*b +: 8] = 8'($random(seed));
      return w;
   endfunction

   initial begin
      reset           <= 1'b1;
      reg_address     <= '0;
      reg_bytecnt     <= '0;
      write_data      <= '0;
      reg_write       <= 1'b0;
      reg_read        <= 1'b0;
      reg_addrvalid   <= 1'b0;
      exttrigger      <= 1'b0;
      crypt_done      <= 1'b0;
      crypt_busy      <= 1'b0;
      crypt_textout   <= '0;
      crypt_cipherout <= '0;
      repeat (reset_cycles) @(posedge usb_clk);
      reset <= 1'b0;

      // reset values and constants
      @(negedge usb_clk);
      check_byte("crypt_start_o", 8'h00, {7'b0, crypt_start});
      check_byte("clksettings_o", 8'h00, {5'b0, clksettings});
      check_byte("user_led_o", 8'h00, {7'b0, user_led});
      host_read(reg_identify_addr, 0, 8'h2E);
      host_read(reg_crypt_type_addr, 0, 8'h02);
      host_read(reg_crypt_rev_addr, 0, 8'h04);
      host_read(reg_clksettings_addr, 0, 8'h00);
      host_read(reg_user_led_addr, 0, 8'h00);
      host_read(8'h20, 0, 8'h00);   // unmapped
      @(posedge usb_clk);
      reg_address   <= reg_identify_addr;
      reg_addrvalid <= 1'b1;        // address valid but no read
      @(negedge usb_clk);
      check_byte("read_data_o", 8'h00, read_data);
      @(posedge usb_clk);
      reg_addrvalid <= 1'b0;
      reg_read      <= 1'b1;        // read without a valid address
      @(negedge usb_clk);
      check_byte("read_data_o", 8'h00, read_data);
      @(posedge usb_clk);
      bus_idle();

      ////////////////////
      // config registers
      ////////////////////
      host_write(reg_clksettings_addr, 0, 8'hFD);
      @(negedge usb_clk);
      check_byte("clksettings_o", 8'hFD & 8'h07, {5'b0, clksettings});
      host_read(reg_clksettings_addr, 0, 8'h05);
      host_write(reg_user_led_addr, 0, 8'h03);
      @(negedge usb_clk);
      check_byte("user_led_o", 8'h01, {7'b0, user_led});
      host_read(reg_user_led_addr, 0, 8'h01);

      ////////////////////
      // crypto inputs, then out of range byte counts
      ////////////////////
      key_exp      = random_word();
      textin_exp   = random_word();
      cipherin_exp = random_word();
      write_word(reg_crypt_key_addr, key_exp);
      write_word(reg_crypt_textin_addr, textin_exp);
      write_word(reg_crypt_cipherin_addr, cipherin_exp);
      @(negedge usb_clk);
      check_word("crypt_key_o", key_exp, crypt_key);
      check_word("crypt_textin_o", textin_exp, crypt_textin);
      check_word("crypt_cipherin_o", cipherin_exp, crypt_cipherin);
      read_word(reg_crypt_key_addr, key_exp);
      read_word(reg_crypt_textin_addr, textin_exp);
      read_word(reg_crypt_cipherin_addr, cipherin_exp);
      host_write(reg_crypt_key_addr, 16, ~key_exp[7:0]);
      host_write(reg_crypt_textin_addr, 127, ~textin_exp[7:0]);
      @(negedge usb_clk);
      check_word("crypt_key_o", key_exp, crypt_key);
      check_word("crypt_textin_o", textin_exp, crypt_textin);
      host_read(reg_crypt_key_addr, 16, 8'h00);

      // go write, one pulse in the next cycle
      host_write(reg_crypt_go_addr, 0, 8'h01);
      for (int i = 0; i < 4; i++) begin
         @(negedge usb_clk);
         check_byte("crypt_start_o", (i == 0) ? 8'h01 : 8'h00, {7'b0, crypt_start});
      end

      // busy reaches the go register after three edges
      @(posedge usb_clk);
      crypt_busy    <= 1'b1;
      reg_address   <= reg_crypt_go_addr;
      reg_bytecnt   <= '0;
      reg_read      <= 1'b1;
      reg_addrvalid <= 1'b1;
      for (int i = 0; i < 5; i++) begin
         @(negedge usb_clk);
         check_byte("read_data_o", (i >= 3) ? 8'h01 : 8'h00, read_data);
      end
      @(posedge usb_clk);
      crypt_busy <= 1'b0;
      bus_idle();

      // held trigger, single pulse two cycles after the first sample
      @(posedge usb_clk);
      exttrigger <= 1'b1;
      for (int i = 0; i < 10; i++) begin
         @(negedge usb_clk);
         check_byte("crypt_start_o", (i == 3) ? 8'h01 : 8'h00, {7'b0, crypt_start});
      end
      @(posedge usb_clk);
      exttrigger <= 1'b0;

      ////////////////////
      // done capture
      ////////////////////
      textout_exp   = random_word();
      cipherout_exp = random_word();
      @(posedge usb_clk);
      crypt_textout   <= textout_exp;
      crypt_cipherout <= cipherout_exp;
      @(posedge usb_clk);
      crypt_done <= 1'b1;
      @(posedge usb_clk);                  // capture edge
      crypt_textout   <= random_word();    // done stays high
      crypt_cipherout <= random_word();
      read_word(reg_crypt_textout_addr, textout_exp);
      read_word(reg_crypt_cipherout_addr, cipherout_exp);
      @(posedge usb_clk);
      crypt_done <= 1'b0;

      repeat (2) @(posedge usb_clk);
      if (u_cw_reg_top.u_props.fail_count != 0) begin
         $display("a concurrent assertion in cw_reg_props failed");
         $display("Done: errors found");
         $fatal(1);
      end else begin
         $display("Done: no errors");
         $finish;
      end
   end

   // stop at the first failed concurrent assertion
   always @(negedge usb_clk) begin
      if (u_cw_reg_top.u_props.fail_count != 0) begin
         $display("a concurrent assertion in cw_reg_props failed");
         $display("Done: errors found");
         $fatal(1);
      end
   end

   initial begin
      #(timeout_ns);
      $display("timeout, the tests did not finish in %0d ns", timeout_ns);
      $display("Done: errors found");
      $fatal(1);
   end

endmodule

`default_nettype wire

/* cw_reg_top.f */
hdl/cw_reg_pkg.sv
hdl/crypt_pkg.sv
hdl/reg_bus_if.sv
hdl/usb_reg_write.sv
hdl/crypt_reg_bank.sv
hdl/crypt_start_ctrl.sv
hdl/usb_reg_read.sv
hdl/cw_reg_top.sv
verification/cw_reg_props.sv
verification/cw_reg_tb.sv

/* Makefile */
# Verilator build and run of the register file testbench
TOP = cw_reg_tb

.PHONY: all lint clean

# build and run, a $fatal in the testbench gives a failing exit status
all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f cw_reg_top.f
	./obj_dir/V$(TOP) +verilator+error+limit+100

# lint of the design with the bound checker
lint:
	verilator --lint-only -Wall --timing --assert --top-module cw_reg_top -f cw_reg_top.f

clean:
	rm -rf obj_dir
